// File: files.f
+incdir+include
rtl/dma_pkg.sv
rtl/opc_wr_if.sv
rtl/ext_opc_buf.sv
rtl/tid_alloc.sv
rtl/ext_cmd_issue.sv
rtl/ext_rsp_track.sv
rtl/dma_rx_path.sv
dv/tb_dma_rx_path.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the DMA receive path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module tb_dma_rx_path -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi

// File: dv/tb_dma_rx_path.sv
`include "dma_settings.svh"

module tb_dma_rx_path import dma_pkg::*;
   ();

   localparam int PERIOD   = 100;
   localparam int GNT_WAIT = 20;
   // Cycle budget: resets, then tests 1 to 5
   localparam int TEST_CYCLES = 30 + 1 + 8 + 37 + 98 + 38;

   logic                          clk;
   logic                          rst_n;
   logic                          cmd_valid;
   opc_t                          cmd_opc;
   len_t                          cmd_len;
   tcdm_add_t                     cmd_tcdm_add;
   logic [`DMA_EXT_ADD_WIDTH-1:0] cmd_ext_add;
   sid_t                          cmd_sid;
   logic                          cmd_gnt;
   logic                          req_valid;
   tid_t                          req_tid;
   logic [`DMA_EXT_ADD_WIDTH-1:0] req_add;
   len_t                          req_len;
   logic                          rsp_valid;
   tid_t                          rsp_tid;
   logic                          rsp_last;
   logic                          tcdm_valid;
   opc_t                          tcdm_opc;
   tcdm_add_t                     tcdm_add;
   len_t                          tcdm_len;
   off_t                          tcdm_ext_off;
   off_t                          tcdm_tcdm_off;
   logic                          synch_valid;
   sid_t                          synch_sid;

   // Expected free list order and context per id
   tid_t       free_q[$];
   opc_entry_t entry_m [`DMA_TID_DEPTH];

   logic [31:0] lfsr;
   int          mismatch_cnt;
   int          fail_cnt;

   dma_rx_path uut
   (
      .clk_i            (clk),
      .rst_ni           (rst_n),
      .cmd_valid_i      (cmd_valid),
      .cmd_opc_i        (cmd_opc),
      .cmd_len_i        (cmd_len),
      .cmd_tcdm_add_i   (cmd_tcdm_add),
      .cmd_ext_add_i    (cmd_ext_add),
      .cmd_sid_i        (cmd_sid),
      .cmd_gnt_o        (cmd_gnt),
      .ext_req_valid_o  (req_valid),
      .ext_req_tid_o    (req_tid),
      .ext_req_add_o    (req_add),
      .ext_req_len_o    (req_len),
      .ext_rsp_valid_i  (rsp_valid),
      .ext_rsp_tid_i    (rsp_tid),
      .ext_rsp_last_i   (rsp_last),
      .tcdm_req_valid_o (tcdm_valid),
      .tcdm_opc_o       (tcdm_opc),
      .tcdm_add_o       (tcdm_add),
      .tcdm_len_o       (tcdm_len),
      .tcdm_ext_off_o   (tcdm_ext_off),
      .tcdm_tcdm_off_o  (tcdm_tcdm_off),
      .synch_valid_o    (synch_valid),
      .synch_sid_o      (synch_sid)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Watchdog, twice the expected run length
   initial
   begin
      #(TEST_CYCLES * 2 * PERIOD);
      $display("ERROR: watchdog expired after %0d cycles, tests did not finish", TEST_CYCLES * 2);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      $display("=== FAIL ===");
      $finish;
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic check_tid(input string name, input tid_t got, input tid_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_opc(input string name, input opc_t got, input opc_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_add(input string name, input tcdm_add_t got, input tcdm_add_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_sid(input string name, input sid_t got, input sid_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_len(input string name, input len_t got, input len_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_off(input string name, input off_t got, input off_t exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic check_ext_add(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic idle_inputs();
      cmd_valid    = 1'b0;
      cmd_opc      = '0;
      cmd_len      = '0;
      cmd_tcdm_add = '0;
      cmd_ext_add  = '0;
      cmd_sid      = '0;
      rsp_valid    = 1'b0;
      rsp_tid      = '0;
      rsp_last     = 1'b0;
   endtask

   // Reset for 5 cycles, free list back to 0..15
   task automatic do_reset();
      @(negedge clk);
      rst_n = 1'b0;
      idle_inputs();
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      free_q.delete();
      for (int i = 0; i < `DMA_TID_DEPTH; i++)
      begin
         free_q.push_back(tid_t'(i));
      end
   endtask

   // Random command fields, called at a falling edge
   task automatic load_cmd(input len_t len);
      cmd_valid    = 1'b1;
      cmd_opc      = opc_t'(rand_bits(`DMA_OPC_WIDTH));
      cmd_len      = len;
      cmd_tcdm_add = tcdm_add_t'(rand_bits(`DMA_TCDM_ADD_WIDTH));
      cmd_ext_add  = rand_bits(`DMA_EXT_ADD_WIDTH);
      cmd_sid      = sid_t'(rand_bits(`DMA_SID_WIDTH));
   endtask

   // Grant seen this cycle, check request and record the entry
   task automatic note_grant();
      tid_t exp_tid;
      if (free_q.size() == 0)
      begin
         fail_cnt++;
         $display("ERROR: command granted at %0t although no id should be free", $time);
      end
      else
      begin
         exp_tid = free_q.pop_front();
         check_bit("ext_req_valid_o", req_valid, 1'b1);
         check_tid("ext_req_tid_o", req_tid, exp_tid);
         check_ext_add("ext_req_add_o", req_add, cmd_ext_add);
         check_len("ext_req_len_o", req_len, cmd_len);
         entry_m[exp_tid].opc      = cmd_opc;
         entry_m[exp_tid].len      = cmd_len;
         entry_m[exp_tid].ext_off  = cmd_ext_add[`DMA_OFF_WIDTH-1:0];
         entry_m[exp_tid].tcdm_add = cmd_tcdm_add;
         entry_m[exp_tid].sid      = cmd_sid;
      end
   endtask

   // Called at a falling edge with the command driven
   task automatic wait_grant();
      int cycles;
      cycles = 0;
      #10;
      while (cmd_gnt !== 1'b1 && cycles < GNT_WAIT)
      begin
         @(negedge clk);
         #10;
         cycles++;
      end
      if (cmd_gnt === 1'b1)
      begin
         note_grant();
      end
      else
      begin
         fail_cnt++;
         $display("ERROR: command not granted within %0d cycles at %0t", GNT_WAIT, $time);
      end
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   task automatic issue_cmd(input len_t len);
      @(negedge clk);
      load_cmd(len);
      wait_grant();
   endtask

   // All beats of one id, then synch; optionally a new command in the release cycle
   task automatic send_beats(input tid_t id, input logic take_same_cycle);
      int n;
      n = (int'(entry_m[id].len) + 7) / 8;
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk);
         rsp_valid = 1'b1;
         rsp_tid   = id;
         rsp_last  = (i == n - 1);
         #10;
         check_bit("tcdm_req_valid_o", tcdm_valid, 1'b1);
         // External load turns into a TCDM store
         check_opc("tcdm_opc_o", tcdm_opc, entry_m[id].opc ^ opc_t'(1));
         check_add("tcdm_add_o", tcdm_add, entry_m[id].tcdm_add + tcdm_add_t'(8 * i));
         check_len("tcdm_len_o", tcdm_len, entry_m[id].len);
         check_off("tcdm_ext_off_o", tcdm_ext_off, entry_m[id].ext_off);
         check_off("tcdm_tcdm_off_o", tcdm_tcdm_off,
                   entry_m[id].tcdm_add[`DMA_OFF_WIDTH-1:0]);
         check_bit("synch_valid_o", synch_valid, 1'b0);
      end
      @(negedge clk);
      rsp_valid = 1'b0;
      rsp_last  = 1'b0;
      if (take_same_cycle)
      begin
         load_cmd(len_t'(8));
      end
      #10;
      check_bit("tcdm_req_valid_o", tcdm_valid, 1'b0);
      check_bit("synch_valid_o", synch_valid, 1'b1);
      check_sid("synch_sid_o", synch_sid, entry_m[id].sid);
      // Pop sees the old head, the push lands behind it
      if (take_same_cycle)
      begin
         check_bit("cmd_gnt_o", cmd_gnt, 1'b1);
         note_grant();
      end
      free_q.push_back(id);
      if (take_same_cycle)
      begin
         @(negedge clk);
         cmd_valid = 1'b0;
      end
   endtask

   task automatic test_reset();
      do_reset();
      #10;
      check_bit("cmd_gnt_o", cmd_gnt, 1'b0);
      check_bit("ext_req_valid_o", req_valid, 1'b0);
      check_bit("tcdm_req_valid_o", tcdm_valid, 1'b0);
      check_bit("synch_valid_o", synch_valid, 1'b0);
   endtask

   task automatic test_single();
      do_reset();
      // 29 bytes, four beats, id 0 from a fresh list
      issue_cmd(len_t'(29));
      send_beats(tid_t'(0), 1'b0);
      @(negedge clk);
      #10;
      check_bit("synch_valid_o", synch_valid, 1'b0);
   endtask

   task automatic test_exhaustion();
      tid_t held;
      do_reset();
      for (int i = 0; i < `DMA_TID_DEPTH; i++)
      begin
         issue_cmd(len_t'(8));
      end
      // Seventeenth command waits for a release
      @(negedge clk);
      load_cmd(len_t'(8));
      #10;
      check_bit("cmd_gnt_o", cmd_gnt, 1'b0);
      check_bit("ext_req_valid_o", req_valid, 1'b0);
      held = tid_t'(rand_bits(`DMA_TID_WIDTH));
      send_beats(held, 1'b0);
      check_bit("cmd_gnt_o", cmd_gnt, 1'b0);
      @(negedge clk);
      wait_grant();
   endtask

   task automatic test_out_of_order();
      tid_t ids[$];
      tid_t tmp;
      int   j;
      do_reset();
      for (int i = 0; i < 6; i++)
      begin
         ids.push_back(free_q[0]);
         issue_cmd(len_t'(1 + rand_bits(6)));
      end
      // Shuffle the completion order
      for (int i = 5; i > 0; i--)
      begin
         j      = int'(rand_bits(3)) % (i + 1);
         tmp    = ids[i];
         ids[i] = ids[j];
         ids[j] = tmp;
      end
      foreach (ids[k])
      begin
         send_beats(ids[k], 1'b0);
      end
      // Walk past the untouched ids into the freed ones
      for (int i = 0; i < `DMA_TID_DEPTH; i++)
      begin
         issue_cmd(len_t'(8));
      end
   endtask

   task automatic test_same_cycle();
      int left;
      do_reset();
      issue_cmd(len_t'(8));
      issue_cmd(len_t'(8));
      send_beats(tid_t'(0), 1'b1);
      // Count unchanged, exactly this many grants remain
      left = free_q.size();
      for (int i = 0; i < left; i++)
      begin
         issue_cmd(len_t'(8));
      end
      @(negedge clk);
      load_cmd(len_t'(8));
      #10;
      check_bit("cmd_gnt_o", cmd_gnt, 1'b0);
      @(negedge clk);
      #10;
      check_bit("cmd_gnt_o", cmd_gnt, 1'b0);
      @(negedge clk);
      cmd_valid = 1'b0;
   endtask

   initial
   begin
      lfsr         = 32'hb929;
      mismatch_cnt = 0;
      fail_cnt     = 0;
      rst_n        = 1'b0;
      idle_inputs();
      test_reset();
      test_single();
      test_exhaustion();
      test_out_of_order();
      test_same_cycle();
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt == 0 && fail_cnt == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: rtl/dma_rx_path.sv
`include "dma_settings.svh"

module dma_rx_path import dma_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rst_ni,

   // Command
   input  logic                          cmd_valid_i,
   input  opc_t                          cmd_opc_i,
   input  len_t                          cmd_len_i,
   input  tcdm_add_t                     cmd_tcdm_add_i,
   input  logic [`DMA_EXT_ADD_WIDTH-1:0] cmd_ext_add_i,
   input  sid_t                          cmd_sid_i,
   output logic                          cmd_gnt_o,

   // External request
   output logic                          ext_req_valid_o,
   output tid_t                          ext_req_tid_o,
   output logic [`DMA_EXT_ADD_WIDTH-1:0] ext_req_add_o,
   output len_t                          ext_req_len_o,

   // External response
   input  logic                          ext_rsp_valid_i,
   input  tid_t                          ext_rsp_tid_i,
   input  logic                          ext_rsp_last_i,

   // TCDM command
   output logic                          tcdm_req_valid_o,
   output opc_t                          tcdm_opc_o,
   output tcdm_add_t                     tcdm_add_o,
   output len_t                          tcdm_len_o,
   output off_t                          tcdm_ext_off_o,
   output off_t                          tcdm_tcdm_off_o,

   // Synch
   output logic                          synch_valid_o,
   output sid_t                          synch_sid_o
);

   // Free list links
   tid_t free_tid;
   logic avail;
   logic take;
   logic rel;
   tid_t rel_tid;

   // Buffer read links
   tid_t      rd_tid;
   opc_t      buf_opc;
   len_t      buf_len;
   tcdm_add_t buf_add;
   off_t      buf_ext_off;
   off_t      buf_tcdm_off;
   sid_t      buf_sid;

   opc_wr_if opc_wr ();

   ext_cmd_issue i_issue
   (
      .cmd_valid_i    (cmd_valid_i),
      .cmd_opc_i      (cmd_opc_i),
      .cmd_len_i      (cmd_len_i),
      .cmd_tcdm_add_i (cmd_tcdm_add_i),
      .cmd_ext_add_i  (cmd_ext_add_i),
      .cmd_sid_i      (cmd_sid_i),
      .cmd_gnt_o      (cmd_gnt_o),
      .free_tid_i     (free_tid),
      .avail_i        (avail),
      .take_o         (take),
      .wr_if          (opc_wr.wr),
      .ext_req_valid_o(ext_req_valid_o),
      .ext_req_tid_o  (ext_req_tid_o),
      .ext_req_add_o  (ext_req_add_o),
      .ext_req_len_o  (ext_req_len_o)
   );

   tid_alloc i_alloc
   (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .take_i        (take),
      .free_tid_o    (free_tid),
      .avail_o       (avail),
      .release_i     (rel),
      .release_tid_i (rel_tid)
   );

   ext_opc_buf i_buf
   (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .wr_if      (opc_wr.rd),
      .rd_tid_i   (rd_tid),
      .tcdm_opc_o (buf_opc),
      .tcdm_len_o (buf_len),
      .tcdm_add_o (buf_add),
      .ext_off_o  (buf_ext_off),
      .tcdm_off_o (buf_tcdm_off),
      .sid_o      (buf_sid)
   );

   ext_rsp_track i_track
   (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .ext_rsp_valid_i  (ext_rsp_valid_i),
      .ext_rsp_tid_i    (ext_rsp_tid_i),
      .ext_rsp_last_i   (ext_rsp_last_i),
      .rd_tid_o         (rd_tid),
      .opc_i            (buf_opc),
      .len_i            (buf_len),
      .add_i            (buf_add),
      .ext_off_i        (buf_ext_off),
      .tcdm_off_i       (buf_tcdm_off),
      .sid_i            (buf_sid),
      .tcdm_req_valid_o (tcdm_req_valid_o),
      .tcdm_opc_o       (tcdm_opc_o),
      .tcdm_add_o       (tcdm_add_o),
      .tcdm_len_o       (tcdm_len_o),
      .tcdm_ext_off_o   (tcdm_ext_off_o),
      .tcdm_tcdm_off_o  (tcdm_tcdm_off_o),
      .release_o        (rel),
      .release_tid_o    (rel_tid),
      .synch_valid_o    (synch_valid_o),
      .synch_sid_o      (synch_sid_o)
   );

endmodule

// File: rtl/ext_rsp_track.sv
`include "dma_settings.svh"

module ext_rsp_track import dma_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // External response beats
   input  logic      ext_rsp_valid_i,
   input  tid_t      ext_rsp_tid_i,
   input  logic      ext_rsp_last_i,

   // Opcode buffer lookup
   output tid_t      rd_tid_o,
   input  opc_t      opc_i,
   input  len_t      len_i,
   input  tcdm_add_t add_i,
   input  off_t      ext_off_i,
   input  off_t      tcdm_off_i,
   input  sid_t      sid_i,

   // TCDM command per beat
   output logic      tcdm_req_valid_o,
   output opc_t      tcdm_opc_o,
   output tcdm_add_t tcdm_add_o,
   output len_t      tcdm_len_o,
   output off_t      tcdm_ext_off_o,
   output off_t      tcdm_tcdm_off_o,

   // Id back to the free list
   output logic      release_o,
   output tid_t      release_tid_o,

   // Transfer done
   output logic      synch_valid_o,
   output sid_t      synch_sid_o
);

   // Enough for len/8 beats plus one for misalignment
   typedef logic [`DMA_LEN_WIDTH-3:0] beat_t;

   beat_t beat_q;
   logic  done_q;
   tid_t  done_tid_q;
   sid_t  done_sid_q;

   // Transaction in progress, for checking
   logic  busy_q;
   tid_t  cur_tid_q;

   // Length rounded up to whole beats
   logic [`DMA_LEN_WIDTH:0] len_rnd;
   beat_t                   max_beats;

   // Buffer read follows the beat id
   assign rd_tid_o = ext_rsp_tid_i;

   // One TCDM command per beat
   assign tcdm_req_valid_o = ext_rsp_valid_i;
   assign tcdm_opc_o       = opc_i;
   // Base plus 8 bytes per beat
   assign tcdm_add_o       = add_i + tcdm_add_t'({beat_q, 3'b000});
   assign tcdm_len_o       = len_i;
   assign tcdm_ext_off_o   = ext_off_i;
   assign tcdm_tcdm_off_o  = tcdm_off_i;

   // Beat index and transaction state
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         beat_q <= '0;
         busy_q <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         done_q <= ext_rsp_valid_i & ext_rsp_last_i;
         if (ext_rsp_valid_i)
         begin
            // Restart on the last beat
            beat_q <= ext_rsp_last_i ? '0 : beat_q + 1'b1;
            busy_q <= ~ext_rsp_last_i;
         end
      end
   end

   // Payload captured with each beat
   always_ff @(posedge clk_i)
   begin
      if (ext_rsp_valid_i)
      begin
         done_tid_q <= ext_rsp_tid_i;
         done_sid_q <= sid_i;
         cur_tid_q  <= ext_rsp_tid_i;
      end
   end

   // Release and synch leave together, one cycle after the last beat
   assign release_o     = done_q;
   assign release_tid_o = done_tid_q;
   assign synch_valid_o = done_q;
   assign synch_sid_o   = done_sid_q;

   assign len_rnd   = {1'b0, len_i} + 7;
   assign max_beats = len_rnd[`DMA_LEN_WIDTH:3];

   // Beats of one transaction arrive back to back
   a_tid_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (ext_rsp_valid_i && busy_q) |-> (ext_rsp_tid_i == cur_tid_q));

   // Never more beats than the stored length allows
   a_beat_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ext_rsp_valid_i |-> (beat_q < max_beats));

endmodule

// File: rtl/ext_cmd_issue.sv
`include "dma_settings.svh"

module ext_cmd_issue import dma_pkg::*;
(
   // Command from the channel
   input  logic                          cmd_valid_i,
   input  opc_t                          cmd_opc_i,
   input  len_t                          cmd_len_i,
   input  tcdm_add_t                     cmd_tcdm_add_i,
   input  logic [`DMA_EXT_ADD_WIDTH-1:0] cmd_ext_add_i,
   input  sid_t                          cmd_sid_i,
   output logic                          cmd_gnt_o,

   // Free list head
   input  tid_t                          free_tid_i,
   input  logic                          avail_i,
   output logic                          take_o,

   // Opcode buffer write
   opc_wr_if.wr                          wr_if,

   // External request
   output logic                          ext_req_valid_o,
   output tid_t                          ext_req_tid_o,
   output logic [`DMA_EXT_ADD_WIDTH-1:0] ext_req_add_o,
   output len_t                          ext_req_len_o
);

   logic gnt;

   // Grant only while an id is free and let the source hold otherwise
   assign gnt       = cmd_valid_i & avail_i;
   assign cmd_gnt_o = gnt;

   // Pop the id on grant
   assign take_o = gnt;

   // Store the context under the id just taken
   assign wr_if.valid          = gnt;
   assign wr_if.tid            = free_tid_i;
   assign wr_if.entry.opc      = cmd_opc_i;
   assign wr_if.entry.len      = cmd_len_i;
   // Low external address bits for realignment
   assign wr_if.entry.ext_off  = cmd_ext_add_i[`DMA_OFF_WIDTH-1:0];
   assign wr_if.entry.tcdm_add = cmd_tcdm_add_i;
   assign wr_if.entry.sid      = cmd_sid_i;

   // Request goes out in the grant cycle
   assign ext_req_valid_o = gnt;
   assign ext_req_tid_o   = free_tid_i;
   assign ext_req_add_o   = cmd_ext_add_i;
   assign ext_req_len_o   = cmd_len_i;

endmodule

// File: rtl/tid_alloc.sv
`include "dma_settings.svh"

module tid_alloc import dma_pkg::*;
(
   input  logic clk_i,
   input  logic rst_ni,

   // Pop side toward the issue unit
   input  logic take_i,
   output tid_t free_tid_o,
   output logic avail_o,

   // Push side from the response tracker
   input  logic release_i,
   input  tid_t release_tid_i
);

   // Count needs one extra bit for the full state
   typedef logic [`DMA_TID_WIDTH:0] cnt_t;

   // Circular free list
   tid_t fifo_q [`DMA_TID_DEPTH];
   tid_t rd_ptr_q;
   tid_t wr_ptr_q;
   cnt_t count_q;

   // One bit per id in flight
   logic [`DMA_TID_DEPTH-1:0] out_q;

   // Head of the list
   assign free_tid_o = fifo_q[rd_ptr_q];
   assign avail_o    = (count_q != '0);

   // Storage and pointers
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         // Ids 0 upward, list full
         for (int i = 0; i < `DMA_TID_DEPTH; i++)
         begin
            fifo_q[i] <= tid_t'(i);
         end
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= cnt_t'(`DMA_TID_DEPTH);
      end
      else
      begin
         if (release_i)
         begin
            fifo_q[wr_ptr_q] <= release_tid_i;
            wr_ptr_q         <= wr_ptr_q + 1'b1;
         end
         if (take_i)
         begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous take and release leave the count alone
         case ({take_i, release_i})
            2'b10:   count_q <= count_q - 1'b1;
            2'b01:   count_q <= count_q + 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Outstanding bitmap
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         out_q <= '0;
      end
      else
      begin
         if (take_i)
         begin
            out_q[free_tid_o] <= 1'b1;
         end
         if (release_i)
         begin
            out_q[release_tid_i] <= 1'b0;
         end
      end
   end

   // Only ids handed out earlier may come back
   a_release_outstanding : assert property (@(posedge clk_i) disable iff (!rst_ni)
      release_i |-> out_q[release_tid_i]);

   // Issue must wait for a free id
   a_take_not_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
      take_i |-> avail_o);

endmodule

// File: rtl/ext_opc_buf.sv
`include "dma_settings.svh"

module ext_opc_buf import dma_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_ni,

   // Write port from the issue unit
   opc_wr_if.rd      wr_if,

   // Read port toward the response tracker
   input  tid_t      rd_tid_i,
   output opc_t      tcdm_opc_o,
   output len_t      tcdm_len_o,
   output tcdm_add_t tcdm_add_o,
   output off_t      ext_off_o,
   output off_t      tcdm_off_o,
   output sid_t      sid_o
);

   // One entry per transaction id
   opc_entry_t mem_q [`DMA_TID_DEPTH];

   // Entry selected by the response id
   opc_entry_t rd_entry;

   // Write on the issue strobe
   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         for (int i = 0; i < `DMA_TID_DEPTH; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (wr_if.valid)
      begin
         mem_q[wr_if.tid] <= wr_if.entry;
      end
   end

   // Combinational read, same cycle as the beat
   assign rd_entry = mem_q[rd_tid_i];

   // External load becomes a TCDM store and vice versa
   always_comb
   begin
      tcdm_opc_o    = rd_entry.opc;
      tcdm_opc_o[0] = ~rd_entry.opc[0];
   end

   assign tcdm_len_o = rd_entry.len;
   assign tcdm_add_o = rd_entry.tcdm_add;
   assign ext_off_o  = rd_entry.ext_off;

   // Realignment offset on the TCDM side
   assign tcdm_off_o = rd_entry.tcdm_add[`DMA_OFF_WIDTH-1:0];

   assign sid_o = rd_entry.sid;

endmodule

// File: rtl/opc_wr_if.sv
interface opc_wr_if import dma_pkg::*;
   ();

   // Write strobe, one entry per edge
   logic       valid;
   // Target slot
   tid_t       tid;
   // Opcode context stored at tid
   opc_entry_t entry;

   // Issue side
   modport wr
   (
      output valid,
      output tid,
      output entry
   );

   // Buffer side
   modport rd
   (
      input valid,
      input tid,
      input entry
   );

endinterface

// File: rtl/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

   // Transaction id on the external bus
   typedef logic [`DMA_TID_WIDTH-1:0] tid_t;

   // Opcode, bit 0 set means load
   typedef logic [`DMA_OPC_WIDTH-1:0] opc_t;

   // Transfer length in bytes
   typedef logic [`DMA_LEN_WIDTH-1:0] len_t;

   // TCDM byte address
   typedef logic [`DMA_TCDM_ADD_WIDTH-1:0] tcdm_add_t;

   // Byte offset within a 64-bit beat
   typedef logic [`DMA_OFF_WIDTH-1:0] off_t;

   // Stream id for the synch pulse
   typedef logic [`DMA_SID_WIDTH-1:0] sid_t;

   // Context kept per outstanding id
   // 12 + 15 + 3 + 12 + 2 = 44 bits
   typedef struct packed
   {
      opc_t      opc;
      len_t      len;
      // Low address bits on the external side
      off_t      ext_off;
      tcdm_add_t tcdm_add;
      sid_t      sid;
   } opc_entry_t;

endpackage

// File: include/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// External transaction id width
`define DMA_TID_WIDTH 4
// One opcode buffer entry and one free list slot per id
`define DMA_TID_DEPTH (1 << `DMA_TID_WIDTH)

// Command fields
`define DMA_OPC_WIDTH 12
`define DMA_LEN_WIDTH 15
`define DMA_TCDM_ADD_WIDTH 12
`define DMA_SID_WIDTH 2
`define DMA_EXT_ADD_WIDTH 32

// Byte offset inside one 64-bit beat
`define DMA_OFF_WIDTH 3

`endif
